/* Makefile */
VERILATOR  ?= verilator
TOP        ?= conv_ctrl_tb
RTL_TOP    ?= conv_ctrl
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
RTL_SRCS   ?= $(shell grep '^source/' $(FILELIST))
SRCS       := $(wildcard source/*.sv tb/*.sv tb/*.svh)
SIM        := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
+incdir+tb
source/conv_pkg.sv
source/layer_config.sv
source/block_sequencer.sv
source/buffer_addr_gen.sv
source/conv_ctrl.sv
tb/conv_ctrl_tb.sv

/* source/block_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module block_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                job_valid,
    input  conv_pkg::cnt_t      fb_count,
    input  conv_pkg::cnt_t      cb_count,
    input  conv_pkg::cnt_t      tail_filters,
    input  conv_pkg::addr_t     filter_size,
    input  conv_pkg::addr_t     input_size,
    input  conv_pkg::addr_t     output_size,
    output logic                step_valid,
    input  logic                step_ready,
    output conv_pkg::cmd_kind_e step_kind,
    output conv_pkg::cnt_t      step_fb,
    output conv_pkg::cnt_t      step_cb,
    output conv_pkg::row_t      step_row,
    output conv_pkg::addr_t     step_idx,
    output logic                step_fb_tail,
    output logic                step_cb_tail,
    input  logic                cmd_last_taken,
    output logic                job_done
);

    conv_pkg::seq_state_e state;
    conv_pkg::cnt_t       fb;
    conv_pkg::cnt_t       cb;
    conv_pkg::row_t       row;       // filter within the block
    conv_pkg::addr_t      idx;
    conv_pkg::cnt_t       fb_nxt;
    conv_pkg::cnt_t       cb_nxt;
    conv_pkg::cnt_t       rows;
    conv_pkg::addr_t      idx_nxt;
    conv_pkg::addr_t      idx_end;
    logic                 fb_last;
    logic                 cb_last;
    logic                 row_last;
    logic                 idx_last;
    logic                 step_take;

    assign fb_nxt   = fb + 1'b1;
    assign cb_nxt   = cb + 1'b1;
    assign idx_nxt  = idx + 1'b1;
    assign fb_last  = (fb_nxt == fb_count);
    assign cb_last  = (cb_nxt == cb_count);
    assign rows     = fb_last ? tail_filters : conv_pkg::cnt_t'(conv_pkg::N_PE);
    assign row_last = (conv_pkg::cnt_t'(row) + 1'b1 == rows);
    assign idx_last = (idx_nxt == idx_end);

    always_comb begin
        case (state)
            conv_pkg::SEQ_FILT: idx_end = filter_size;
            conv_pkg::SEQ_LINE: idx_end = input_size;
            default:            idx_end = output_size;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // step outputs, all taken from registered state
    //////////////////////////////////////////////////////////////////////

    assign step_valid = (state == conv_pkg::SEQ_FILT) || (state == conv_pkg::SEQ_LINE) ||
                        (state == conv_pkg::SEQ_WB);
    assign step_take  = step_valid && step_ready;

    always_comb begin
        case (state)
            conv_pkg::SEQ_FILT: step_kind = conv_pkg::CMD_FILT;
            conv_pkg::SEQ_LINE: step_kind = conv_pkg::CMD_LINE;
            default:            step_kind = conv_pkg::CMD_WB;
        endcase
    end

    assign step_fb      = fb;
    assign step_cb      = cb;
    assign step_row     = row;
    assign step_idx     = idx;
    assign step_fb_tail = fb_last;
    // during write-back the cb flag marks the step that leaves SEQ_WB
    assign step_cb_tail = (state == conv_pkg::SEQ_WB) ? idx_last : cb_last;

    //////////////////////////////////////////////////////////////////////
    // loop nest: fb, cb, then filters, then input
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= conv_pkg::SEQ_IDLE;
            fb       <= '0;
            cb       <= '0;
            row      <= '0;
            idx      <= '0;
            job_done <= 1'b0;
        end else begin
            job_done <= 1'b0;
            case (state)
                conv_pkg::SEQ_IDLE: begin
                    if (job_valid) begin
                        fb    <= '0;
                        state <= conv_pkg::SEQ_FB;
                    end
                end
                conv_pkg::SEQ_FB: begin
                    cb    <= '0;
                    state <= conv_pkg::SEQ_CB;
                end
                conv_pkg::SEQ_CB: begin
                    row   <= '0;
                    idx   <= '0;
                    state <= conv_pkg::SEQ_FILT;
                end
                conv_pkg::SEQ_FILT: begin
                    if (step_take) begin
                        idx <= idx_last ? '0 : idx_nxt;
                        if (idx_last && row_last) begin
                            state <= conv_pkg::SEQ_LINE;
                        end else if (idx_last) begin
                            row <= row + 1'b1;
                        end
                    end
                end
                conv_pkg::SEQ_LINE: begin
                    if (step_take) begin
                        idx <= idx_last ? '0 : idx_nxt;
                        if (idx_last && cb_last) begin
                            state <= conv_pkg::SEQ_WB;    // last cb of this fb
                        end else if (idx_last) begin
                            cb    <= cb_nxt;
                            state <= conv_pkg::SEQ_CB;
                        end
                    end
                end
                conv_pkg::SEQ_WB: begin
                    if (step_take) begin
                        idx <= idx_last ? '0 : idx_nxt;
                        if (idx_last && fb_last) begin
                            state <= conv_pkg::SEQ_DONE;
                        end else if (idx_last) begin
                            fb    <= fb_nxt;
                            state <= conv_pkg::SEQ_FB;
                        end
                    end
                end
                conv_pkg::SEQ_DONE: begin
                    if (cmd_last_taken) begin
                        job_done <= 1'b1;
                        state    <= conv_pkg::SEQ_IDLE;
                    end
                end
                default: state <= conv_pkg::SEQ_IDLE;
            endcase
        end
    end

    a_step_hold: assert property (@(posedge clk) disable iff (rst)
        step_valid && !step_ready |=> step_valid && $stable({step_kind, step_fb, step_cb,
            step_row, step_idx, step_fb_tail, step_cb_tail}));

    // a new job only lands on an idle sequencer
    a_job_when_idle: assert property (@(posedge clk) disable iff (rst)
        job_valid |-> state == conv_pkg::SEQ_IDLE);

endmodule

`default_nettype wire

/* source/buffer_addr_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module buffer_addr_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 step_valid,
    output logic                 step_ready,
    input  conv_pkg::cmd_kind_e  step_kind,
    input  conv_pkg::cnt_t       step_fb,
    input  conv_pkg::cnt_t       step_cb,
    input  conv_pkg::row_t       step_row,
    input  conv_pkg::addr_t      step_idx,
    input  logic                 step_fb_tail,
    input  logic                 step_cb_tail,
    input  conv_pkg::addr_t      filter_size,
    input  conv_pkg::addr_t      input_size,
    input  conv_pkg::addr_t      output_size,
    input  conv_pkg::addr_t      filter_base,
    input  conv_pkg::addr_t      filter_stride,
    input  conv_pkg::lane_mask_t chan_tail_mask,
    input  conv_pkg::lane_mask_t filt_tail_mask,
    output logic                 cmd_valid,
    input  logic                 cmd_ready,
    output conv_pkg::cmd_kind_e  cmd_kind,
    output conv_pkg::row_t       cmd_row,
    output conv_pkg::lane_mask_t cmd_mask,
    output conv_pkg::addr_t      cmd_addr,
    output logic                 cmd_last_taken
);

    logic [conv_pkg::CMD_PAY_W-1:0] new_pay;
    logic [conv_pkg::CMD_PAY_W-1:0] out_pay;
    logic [conv_pkg::CMD_PAY_W-1:0] skid_pay;
    logic                           skid_valid;
    logic                           step_take;
    logic                           out_free;
    logic                           out_last;
    logic [conv_pkg::KIND_W-1:0]    kind_bits;
    conv_pkg::addr_t                new_addr;
    conv_pkg::lane_mask_t           new_mask;
    conv_pkg::lane_mask_t           chan_mask;
    conv_pkg::lane_mask_t           filt_mask;
    conv_pkg::row_t                 new_row;
    logic                           new_last;

    assign chan_mask = step_cb_tail ? chan_tail_mask : '1;
    assign filt_mask = step_fb_tail ? filt_tail_mask : '1;

    always_comb begin
        new_row  = '0;
        new_mask = chan_mask;
        new_last = 1'b0;
        case (step_kind)
            conv_pkg::CMD_FILT: begin
                new_row  = step_row;
                new_addr = filter_base + filter_stride * conv_pkg::addr_t'(step_cb)
                         + filter_size * ((conv_pkg::addr_t'(step_fb) << conv_pkg::LOG_N_PE)
                         + conv_pkg::addr_t'(step_row)) + step_idx;
            end
            conv_pkg::CMD_LINE: begin
                new_addr = input_size * conv_pkg::addr_t'(step_cb) + step_idx;
            end
            default: begin
                new_addr = output_size * conv_pkg::addr_t'(step_fb) + step_idx;
                new_mask = filt_mask;
                new_last = step_fb_tail && step_cb_tail;    // final write-back of the job
            end
        endcase
    end

    assign new_pay = {step_kind, new_row, new_mask, new_addr, new_last};
    assign {kind_bits, cmd_row, cmd_mask, cmd_addr, out_last} = out_pay;
    assign cmd_kind = conv_pkg::cmd_kind_e'(kind_bits);

    //////////////////////////////////////////////////////////////////////
    // output register with one skid slot
    //////////////////////////////////////////////////////////////////////

    assign step_ready     = !skid_valid;
    assign step_take      = step_valid && step_ready;
    assign out_free       = !cmd_valid || cmd_ready;
    assign cmd_last_taken = cmd_valid && cmd_ready && out_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            cmd_valid  <= skid_valid || step_take;
            skid_valid <= 1'b0;
        end else if (step_take) begin
            skid_valid <= 1'b1;    // output stalled, park it
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_pay <= skid_valid ? skid_pay : new_pay;
        end else if (step_take) begin
            skid_pay <= new_pay;
        end
    end

endmodule

`default_nettype wire

/* source/conv_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_valid,
    output logic                 cfg_ready,
    input  conv_pkg::cnt_t       cfg_channels,
    input  conv_pkg::cnt_t       cfg_filters,
    input  conv_pkg::dim_t       cfg_data_wid,
    input  conv_pkg::dim_t       cfg_data_hei,
    input  conv_pkg::dim_t       cfg_filter_wid,
    input  conv_pkg::dim_t       cfg_filter_hei,
    input  logic                 cmd_ready,
    output logic                 cmd_valid,
    output conv_pkg::cmd_kind_e  cmd_kind,
    output conv_pkg::row_t       cmd_row,
    output conv_pkg::lane_mask_t cmd_mask,
    output conv_pkg::addr_t      cmd_addr,
    output logic                 done
);

    // layer geometry
    logic                 job_valid;
    conv_pkg::cnt_t       fb_count;
    conv_pkg::cnt_t       cb_count;
    conv_pkg::cnt_t       tail_filters;
    conv_pkg::addr_t      filter_size;
    conv_pkg::addr_t      input_size;
    conv_pkg::addr_t      output_size;
    conv_pkg::addr_t      filter_base;
    conv_pkg::addr_t      filter_stride;
    conv_pkg::lane_mask_t chan_tail_mask;
    conv_pkg::lane_mask_t filt_tail_mask;

    // sequencer steps
    logic                 step_valid;
    logic                 step_ready;
    conv_pkg::cmd_kind_e  step_kind;
    conv_pkg::cnt_t       step_fb;
    conv_pkg::cnt_t       step_cb;
    conv_pkg::row_t       step_row;
    conv_pkg::addr_t      step_idx;
    logic                 step_fb_tail;
    logic                 step_cb_tail;
    logic                 cmd_last_taken;

    layer_config u_layer_config (
        .clk, .rst,
        .cfg_valid, .cfg_ready, .cfg_channels, .cfg_filters,
        .cfg_data_wid, .cfg_data_hei, .cfg_filter_wid, .cfg_filter_hei,
        .job_valid, .fb_count, .cb_count, .tail_filters,
        .filter_size, .input_size, .output_size, .filter_base, .filter_stride,
        .chan_tail_mask, .filt_tail_mask,
        .job_done (done)
    );

    block_sequencer u_block_sequencer (
        .clk, .rst,
        .job_valid, .fb_count, .cb_count, .tail_filters,
        .filter_size, .input_size, .output_size,
        .step_valid, .step_ready, .step_kind, .step_fb, .step_cb,
        .step_row, .step_idx, .step_fb_tail, .step_cb_tail,
        .cmd_last_taken,
        .job_done (done)
    );

    buffer_addr_gen u_buffer_addr_gen (
        .clk, .rst,
        .step_valid, .step_ready, .step_kind, .step_fb, .step_cb,
        .step_row, .step_idx, .step_fb_tail, .step_cb_tail,
        .filter_size, .input_size, .output_size, .filter_base, .filter_stride,
        .chan_tail_mask, .filt_tail_mask,
        .cmd_valid, .cmd_ready, .cmd_kind, .cmd_row, .cmd_mask, .cmd_addr,
        .cmd_last_taken
    );

endmodule

`default_nettype wire

/* source/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    //////////////////////////////////////////////////////////////////////
    // array geometry and field widths
    //////////////////////////////////////////////////////////////////////

    localparam int N_PE     = 4;    // lanes = PE rows = block edge
    localparam int LOG_N_PE = 2;
    localparam int CNT_W    = 8;    // channel / filter counts
    localparam int DIM_W    = 5;    // spatial dims, 1 to 16
    localparam int ADDR_W   = 16;   // buffer word address
    localparam int KIND_W   = 2;

    // packed command word held in the output register and skid slot
    localparam int CMD_PAY_W = KIND_W + LOG_N_PE + N_PE + ADDR_W + 1;

    typedef logic [CNT_W-1:0]    cnt_t;
    typedef logic [DIM_W-1:0]    dim_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [N_PE-1:0]     lane_mask_t;
    typedef logic [LOG_N_PE-1:0] row_t;

    //////////////////////////////////////////////////////////////////////
    // command kinds and sequencer states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [KIND_W-1:0] {
        CMD_FILT = 2'd0,    // filter load, input buffer
        CMD_LINE = 2'd1,    // input line stream, input buffer
        CMD_WB   = 2'd2     // write-back, output buffer
    } cmd_kind_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_FB,     // filter block setup
        SEQ_CB,     // channel block setup
        SEQ_FILT,
        SEQ_LINE,
        SEQ_WB,
        SEQ_DONE    // wait for the last write-back to leave
    } seq_state_e;

endpackage

`default_nettype wire

/* source/layer_config.sv */
`timescale 1ns/100ps
`default_nettype none

module layer_config (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_valid,
    output logic                 cfg_ready,
    input  conv_pkg::cnt_t       cfg_channels,
    input  conv_pkg::cnt_t       cfg_filters,
    input  conv_pkg::dim_t       cfg_data_wid,
    input  conv_pkg::dim_t       cfg_data_hei,
    input  conv_pkg::dim_t       cfg_filter_wid,
    input  conv_pkg::dim_t       cfg_filter_hei,
    output logic                 job_valid,
    output conv_pkg::cnt_t       fb_count,
    output conv_pkg::cnt_t       cb_count,
    output conv_pkg::cnt_t       tail_filters,
    output conv_pkg::addr_t      filter_size,
    output conv_pkg::addr_t      input_size,
    output conv_pkg::addr_t      output_size,
    output conv_pkg::addr_t      filter_base,
    output conv_pkg::addr_t      filter_stride,
    output conv_pkg::lane_mask_t chan_tail_mask,
    output conv_pkg::lane_mask_t filt_tail_mask,
    input  logic                 job_done
);

    conv_pkg::cnt_t  channels;
    conv_pkg::cnt_t  filters;
    conv_pkg::dim_t  data_wid;
    conv_pkg::dim_t  data_hei;
    conv_pkg::dim_t  filt_wid;
    conv_pkg::dim_t  filt_hei;
    logic            busy;
    logic            fields_valid;    // stage 1 holds a fresh layer
    logic            cfg_take;
    conv_pkg::cnt_t  cb_c;
    conv_pkg::dim_t  out_wid_c;
    conv_pkg::dim_t  out_hei_c;
    conv_pkg::addr_t in_size_c;
    conv_pkg::addr_t filt_size_c;

    // blocks of N_PE, rounded up
    function automatic conv_pkg::cnt_t blocks(input conv_pkg::cnt_t n);
        return (n >> conv_pkg::LOG_N_PE) + conv_pkg::cnt_t'(|n[conv_pkg::LOG_N_PE-1:0]);
    endfunction

    // lanes below n mod N_PE, all lanes when it divides evenly
    function automatic conv_pkg::lane_mask_t tail_mask(input conv_pkg::cnt_t n);
        conv_pkg::lane_mask_t          m;
        logic [conv_pkg::LOG_N_PE-1:0] rem;
        rem = n[conv_pkg::LOG_N_PE-1:0];
        for (int i = 0; i < conv_pkg::N_PE; i++) begin
            m[i] = (rem == '0) || (i < rem);
        end
        return m;
    endfunction

    assign cfg_ready = !busy;
    assign cfg_take  = cfg_valid && cfg_ready;

    assign cb_c        = blocks(channels);
    assign out_wid_c   = data_wid - filt_wid + 1'b1;    // valid conv, stride 1
    assign out_hei_c   = data_hei - filt_hei + 1'b1;
    assign in_size_c   = conv_pkg::addr_t'(data_wid) * conv_pkg::addr_t'(data_hei);
    assign filt_size_c = conv_pkg::addr_t'(filt_wid) * conv_pkg::addr_t'(filt_hei);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            fields_valid <= 1'b0;
            job_valid    <= 1'b0;
        end else begin
            fields_valid <= cfg_take;
            job_valid    <= fields_valid;
            if (cfg_take) begin
                busy <= 1'b1;
            end else if (job_done) begin
                busy <= 1'b0;
            end
        end
    end

    // stage 1 fields, stage 2 products
    always_ff @(posedge clk) begin
        if (cfg_take) begin
            channels <= cfg_channels;
            filters  <= cfg_filters;
            data_wid <= cfg_data_wid;
            data_hei <= cfg_data_hei;
            filt_wid <= cfg_filter_wid;
            filt_hei <= cfg_filter_hei;
        end
        if (fields_valid) begin
            fb_count       <= blocks(filters);
            cb_count       <= cb_c;
            tail_filters   <= (filters[conv_pkg::LOG_N_PE-1:0] == '0) ?
                              conv_pkg::cnt_t'(conv_pkg::N_PE) :
                              conv_pkg::cnt_t'(filters[conv_pkg::LOG_N_PE-1:0]);
            filter_size    <= filt_size_c;
            input_size     <= in_size_c;
            output_size    <= conv_pkg::addr_t'(out_wid_c) * conv_pkg::addr_t'(out_hei_c);
            filter_base    <= in_size_c * conv_pkg::addr_t'(cb_c);   // filters sit past inputs
            filter_stride  <= filt_size_c * conv_pkg::addr_t'(filters);
            chan_tail_mask <= tail_mask(channels);
            filt_tail_mask <= tail_mask(filters);
        end
    end

    a_done_only_busy: assert property (@(posedge clk) disable iff (rst)
        job_done |-> busy && !fields_valid && !job_valid);

endmodule

`default_nettype wire

/* tb/conv_ref_model.svh */
// reference command stream for one layer, built from the addressing rules
// queue word layout {kind, row, mask, addr}

// lanes below n mod N_PE, or every lane when N_PE divides n
function automatic logic [conv_pkg::N_PE-1:0] lanes_below(input int n);
    int rem;
    rem = n % conv_pkg::N_PE;
    if (rem == 0) begin
        return '1;
    end
    return conv_pkg::N_PE'((1 << rem) - 1);
endfunction

function automatic int ceil_blocks(input int n);
    return (n + conv_pkg::N_PE - 1) / conv_pkg::N_PE;
endfunction

task automatic push_cmd(input conv_pkg::cmd_kind_e kind, input int row,
                        input logic [conv_pkg::N_PE-1:0] mask, input int addr);
    exp_q.push_back({kind, conv_pkg::row_t'(row), mask, conv_pkg::addr_t'(addr)});
endtask

// fb outer, cb inner, then filters of the block, then the input line
task automatic build_commands(input int ch, input int fl, input int dw, input int dh,
                              input int fw, input int fh);
    int fbs;
    int cbs;
    int fsz;
    int isz;
    int osz;
    int fbase;
    int fstride;
    int rows;
    logic [conv_pkg::N_PE-1:0] mask;
    fbs     = ceil_blocks(fl);
    cbs     = ceil_blocks(ch);
    fsz     = fw * fh;
    isz     = dw * dh;
    osz     = (dh - fh + 1) * (dw - fw + 1);    // valid conv, stride 1
    fbase   = isz * cbs;                        // filter region past all inputs
    fstride = fsz * fl;
    exp_q.delete();
    for (int fb = 0; fb < fbs; fb++) begin
        rows = (fb == fbs - 1) ? fl - conv_pkg::N_PE * (fbs - 1) : conv_pkg::N_PE;
        for (int cb = 0; cb < cbs; cb++) begin
            mask = (cb == cbs - 1) ? lanes_below(ch) : '1;
            for (int r = 0; r < rows; r++) begin
                for (int i = 0; i < fsz; i++) begin
                    push_cmd(conv_pkg::CMD_FILT, r, mask,
                             fbase + fstride * cb + fsz * (conv_pkg::N_PE * fb + r) + i);
                end
            end
            for (int i = 0; i < isz; i++) begin
                push_cmd(conv_pkg::CMD_LINE, 0, mask, isz * cb + i);
            end
        end
        mask = (fb == fbs - 1) ? lanes_below(fl) : '1;
        for (int i = 0; i < osz; i++) begin
            push_cmd(conv_pkg::CMD_WB, 0, mask, osz * fb + i);
        end
    end
endtask

/* tb/conv_ctrl_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_ctrl_tb;

    localparam int CMD_W = conv_pkg::KIND_W + conv_pkg::LOG_N_PE + conv_pkg::N_PE
                         + conv_pkg::ADDR_W;

    logic                 clk;
    logic                 rst;
    logic                 cfg_valid;
    logic                 cfg_ready;
    conv_pkg::cnt_t       cfg_channels;
    conv_pkg::cnt_t       cfg_filters;
    conv_pkg::dim_t       cfg_data_wid;
    conv_pkg::dim_t       cfg_data_hei;
    conv_pkg::dim_t       cfg_filter_wid;
    conv_pkg::dim_t       cfg_filter_hei;
    logic                 cmd_ready;
    logic                 cmd_valid;
    conv_pkg::cmd_kind_e  cmd_kind;
    conv_pkg::row_t       cmd_row;
    conv_pkg::lane_mask_t cmd_mask;
    conv_pkg::addr_t      cmd_addr;
    logic                 done;

    logic [CMD_W-1:0]     cmd_word;
    logic [CMD_W-1:0]     exp_q[$];    // expected commands of the running job
    logic [CMD_W-1:0]     exp_head;
    int                   exp_left;
    logic                 in_job;
    logic                 bp_on;       // random cmd_ready
    string                test_name;
    int                   cycle_count = 0;
    int                   cycle_limit;

    `include "conv_ref_model.svh"

    conv_ctrl UUT (
        .clk, .rst,
        .cfg_valid, .cfg_ready, .cfg_channels, .cfg_filters,
        .cfg_data_wid, .cfg_data_hei, .cfg_filter_wid, .cfg_filter_hei,
        .cmd_ready, .cmd_valid, .cmd_kind, .cmd_row, .cmd_mask, .cmd_addr,
        .done
    );

    assign cmd_word = {cmd_kind, cmd_row, cmd_mask, cmd_addr};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_value(input string what, input logic [CMD_W-1:0] expected,
                                input logic [CMD_W-1:0] actual);
        $display("FAILED %s: %s expected %h, actual %h", test_name, what, expected, actual);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_fault(input string msg);
        $display("%s: %s", test_name, msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !cmd_valid && !done && cfg_ready)
        else report_fault("outputs not idle after reset");

    a_cmd_expected: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && cmd_ready |-> exp_left != 0)
        else report_fault("command taken when none was expected");

    a_cmd_match: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && cmd_ready |-> cmd_word == exp_head)
        else report_value("cmd {kind,row,mask,addr}", $sampled(exp_head), $sampled(cmd_word));

    a_cmd_stall: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_word))
        else report_fault("stalled command changed or dropped");

    a_first_cmd_gap: assert property (@(posedge clk) disable iff (rst)
        cfg_valid && cfg_ready |=> !cmd_valid ##1 !cmd_valid ##1 !cmd_valid)
        else report_fault("command came too soon after the configuration");

    a_done_after_last: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && cmd_ready && exp_left == 1 |=> done)
        else report_fault("done missing one cycle after the last write-back");

    a_done_only_last: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(cmd_valid && cmd_ready && exp_left == 1) && exp_left == 0)
        else report_fault("done without a preceding last write-back");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else report_fault("done longer than one cycle");

    a_busy_in_job: assert property (@(posedge clk) disable iff (rst) in_job |-> !cfg_ready)
        else report_fault("cfg_ready high during a job");

    a_ready_after_done: assert property (@(posedge clk) disable iff (rst) done |=> cfg_ready)
        else report_fault("cfg_ready still low after done");

    //////////////////////////////////////////////////////////////////////
    // scoreboard, back-pressure and run limit
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            in_job <= 1'b0;
        end else begin
            if (cfg_valid && cfg_ready) begin
                in_job <= 1'b1;
            end else if (done) begin
                in_job <= 1'b0;
            end
            if (cmd_valid && cmd_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
        end
        exp_left <= exp_q.size();
        exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            cmd_ready <= 1'b0;
        end else begin
            cmd_ready <= bp_on ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("TB FAILED");
            $fatal(1, "timeout, run not finished after %0d cycles", cycle_count);
        end
    end

    // one layer from handshake to done
    task automatic run_layer(input string name, input int ch, input int fl, input int dw,
                             input int dh, input int fw, input int fh, input bit bp);
        do @(negedge clk); while (!cfg_ready);
        test_name = name;
        bp_on     = bp;
        build_commands(ch, fl, dw, dh, fw, fh);
        @(posedge clk);
        cfg_valid      <= 1'b1;
        cfg_channels   <= conv_pkg::cnt_t'(ch);
        cfg_filters    <= conv_pkg::cnt_t'(fl);
        cfg_data_wid   <= conv_pkg::dim_t'(dw);
        cfg_data_hei   <= conv_pkg::dim_t'(dh);
        cfg_filter_wid <= conv_pkg::dim_t'(fw);
        cfg_filter_hei <= conv_pkg::dim_t'(fh);
        @(posedge clk);    // handshake, cfg_ready was high
        cfg_valid <= 1'b0;
        do @(negedge clk); while (!done);
    endtask

    initial begin
        int total;
        void'($urandom(21817));
        rst            = 1'b1;
        cfg_valid      = 1'b0;
        cfg_channels   = '0;
        cfg_filters    = '0;
        cfg_data_wid   = '0;
        cfg_data_hei   = '0;
        cfg_filter_wid = '0;
        cfg_filter_hei = '0;
        cmd_ready      = 1'b0;
        bp_on          = 1'b0;
        test_name      = "reset";
        // each layer runs twice, once per ready pattern
        build_commands(8, 8, 4, 4, 3, 3);
        total = exp_q.size();
        build_commands(6, 5, 5, 4, 2, 2);
        total += exp_q.size();
        exp_q.delete();
        cycle_limit = 4 * 2 * total + 200 * 4;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        run_layer("full_block", 8, 8, 4, 4, 3, 3, 1'b0);
        run_layer("partial_block", 6, 5, 5, 4, 2, 2, 1'b0);
        run_layer("full_block_stall", 8, 8, 4, 4, 3, 3, 1'b1);
        run_layer("partial_block_stall", 6, 5, 5, 4, 2, 2, 1'b1);

        repeat (3) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
